/* debug_config.svh */
`ifndef DEBUG_CONFIG_SVH
`define DEBUG_CONFIG_SVH

// Payload bytes kept per inbound message
`define MSG_MAX_PAYLOAD_LEN 5

// Entries in each message queue
`define QUEUE_DEPTH 4

// Sample memory of 16-bit words
`define MEM_WORDS 64
`define MEM_ADDR_WIDTH 6

`endif

/* debugPkg.sv */
`default_nettype none

`include "debug_config.svh"

package debugPkg;

    typedef enum logic [7:0] {
        Nop     = 8'd0,
        SetLed  = 8'd1,
        ReadMem = 8'd2
    } msgTypeT;

    // Payload byte 0 sits in the lowest bits
    typedef struct packed {
        logic [7:0]                                msgType;
        logic [7:0]                                payloadLen;
        logic [`MSG_MAX_PAYLOAD_LEN-1:0][7:0]      payload;
    } msgT;

    // Fill word: address in the high byte, its inverse in the low byte
    function automatic logic [15:0] patternWord(input logic [`MEM_ADDR_WIDTH-1:0] addr);
        logic [7:0] addrByte;
        addrByte = 8'(addr);
        return {addrByte, ~addrByte};
    endfunction

endpackage

`default_nettype wire

/* msgQueue.sv */
`default_nettype none

`include "debug_config.svh"

module msgQueue #(
    parameter type itemT = logic [7:0],
    parameter int  depth = `QUEUE_DEPTH
) (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  itemT item,
    input  logic pop,
    output itemT front,
    output logic empty,
    output logic full
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    itemT            mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            doPush;
    logic            doPop;

    // Pushes into a full queue are dropped
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign front = mem[rdPtr];
    assign empty = (count == '0);
    assign full  = (count == cntW'(depth));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= item;
        end
    end

endmodule

`default_nettype wire

/* serialRx.sv */
`default_nettype none

`include "debug_config.svh"

module serialRx (
    input  logic          clk,
    input  logic          rstN,
    input  logic          debugCs,
    input  logic          debugDi,
    output logic          msgPush,
    output debugPkg::msgT msg
);

    typedef enum logic [1:0] {RxType, RxLen, RxPayload} rxStateT;

    rxStateT    state;
    logic [2:0] bitCnt;
    logic [6:0] shiftReg;
    logic [7:0] rxByte;
    logic [7:0] payCnt;
    logic       byteDone;

    // The byte completes on the edge that samples its last bit
    assign rxByte   = {shiftReg, debugDi};
    assign byteDone = (bitCnt == 3'd7);

    always_ff @(posedge clk) begin
        if (!rstN || !debugCs) begin
            state   <= RxType;
            bitCnt  <= '0;
            payCnt  <= '0;
            msgPush <= 1'b0;
        end else begin
            msgPush  <= 1'b0;
            bitCnt   <= bitCnt + 3'd1;
            shiftReg <= rxByte[6:0];
            if (byteDone) begin
                case (state)
                    // Zero bytes between messages are no-ops
                    RxType: begin
                        if (rxByte != 8'h00) begin
                            msg.msgType <= rxByte;
                            msg.payload <= '0;
                            state       <= RxLen;
                        end
                    end
                    RxLen: begin
                        msg.payloadLen <= rxByte;
                        payCnt         <= '0;
                        if (rxByte == 8'h00) begin
                            msgPush <= 1'b1;
                            state   <= RxType;
                        end else begin
                            state <= RxPayload;
                        end
                    end
                    RxPayload: begin
                        // Bytes beyond the kept payload are only counted
                        for (int i = 0; i < `MSG_MAX_PAYLOAD_LEN; i++) begin
                            if (payCnt == 8'(i)) begin
                                msg.payload[i] <= rxByte;
                            end
                        end
                        payCnt <= payCnt + 8'd1;
                        if (payCnt == msg.payloadLen - 8'd1) begin
                            msgPush <= 1'b1;
                            state   <= RxType;
                        end
                    end
                    default: state <= RxType;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* serialTx.sv */
`default_nettype none

module serialTx (
    input  logic       clk,
    input  logic       rstN,
    input  logic       debugCs,
    input  logic [7:0] qFront,
    input  logic       qEmpty,
    output logic       qPop,
    output logic       debugDo
);

    logic [2:0] bitCnt;
    logic [6:0] shiftReg;
    logic [7:0] loadByte;

    // Idle link carries zero bytes
    assign loadByte = qEmpty ? 8'h00 : qFront;

    always_ff @(posedge clk) begin
        if (!rstN || !debugCs) begin
            bitCnt  <= '0;
            qPop    <= 1'b0;
            debugDo <= 1'b0;
        end else begin
            bitCnt <= bitCnt + 3'd1;
            qPop   <= 1'b0;
            if (bitCnt == 3'd0) begin
                // Byte boundary: MSB goes out now, the rest waits in the shifter
                debugDo  <= loadByte[7];
                shiftReg <= loadByte[6:0];
                qPop     <= !qEmpty;
            end else begin
                debugDo  <= shiftReg[6];
                shiftReg <= {shiftReg[5:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* msgSender.sv */
`default_nettype none

module msgSender (
    input  logic              clk,
    input  logic              rstN,
    input  logic              sendStart,
    input  debugPkg::msgTypeT sendType,
    input  logic [7:0]        sendLen,
    input  logic [7:0]        payloadByte,
    input  logic              qFull,
    output logic              byteReq,
    output logic              sendBusy,
    output logic              qPush,
    output logic [7:0]        qItem
);

    typedef enum logic [2:0] {
        Idle,
        PushType,
        PushLen,
        Request,
        Capture,
        PushPayload
    } sendStateT;

    sendStateT  state;
    logic [7:0] dataReg;
    logic [7:0] byteCnt;

    // Push straight from the state so a full queue stalls the same cycle
    always_comb begin
        qPush = 1'b0;
        qItem = dataReg;
        case (state)
            PushType: begin
                qPush = !qFull;
                qItem = sendType;
            end
            PushLen: begin
                qPush = !qFull;
                qItem = sendLen;
            end
            PushPayload: qPush = !qFull;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= Idle;
            sendBusy <= 1'b0;
            byteReq  <= 1'b0;
            byteCnt  <= '0;
        end else begin
            byteReq <= 1'b0;
            case (state)
                Idle: begin
                    if (sendStart) begin
                        sendBusy <= 1'b1;
                        state    <= PushType;
                    end
                end
                PushType: begin
                    if (!qFull) begin
                        state <= PushLen;
                    end
                end
                PushLen: begin
                    if (!qFull) begin
                        byteCnt <= '0;
                        if (sendLen == 8'd0) begin
                            sendBusy <= 1'b0;
                            state    <= Idle;
                        end else begin
                            byteReq <= 1'b1;
                            state   <= Request;
                        end
                    end
                end
                // Engine registers the byte at the end of this cycle
                Request: state <= Capture;
                Capture: begin
                    dataReg <= payloadByte;
                    state   <= PushPayload;
                end
                PushPayload: begin
                    if (!qFull) begin
                        byteCnt <= byteCnt + 8'd1;
                        if (byteCnt == sendLen - 8'd1) begin
                            sendBusy <= 1'b0;
                            state    <= Idle;
                        end else begin
                            byteReq <= 1'b1;
                            state   <= Request;
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* cmdEngine.sv */
`default_nettype none

`include "debug_config.svh"

module cmdEngine (
    input  logic              clk,
    input  logic              rstN,
    input  debugPkg::msgT     inFront,
    input  logic              inEmpty,
    output logic              inPop,
    output logic              sendStart,
    output debugPkg::msgTypeT sendType,
    output logic [7:0]        sendLen,
    input  logic              byteReq,
    input  logic              sendBusy,
    output logic [7:0]        payloadByte,
    output logic [3:0]        led
);

    import debugPkg::*;

    localparam int addrW = `MEM_ADDR_WIDTH;

    typedef enum logic [2:0] {Fill, Idle, Decode, Start, Busy} engStateT;

    engStateT         state;
    logic [15:0]      mem [`MEM_WORDS];
    logic [addrW-1:0] fillAddr;
    logic [addrW-1:0] rdAddr;
    logic [15:0]      rdWord;
    logic [7:0]       cmdType;
    logic [7:0]       cmdArg0;
    logic [7:0]       cmdArg1;
    logic [6:0]       wordCnt;
    logic             hiNext;

    assign inPop   = (state == Idle) && !inEmpty;
    assign rdWord  = mem[rdAddr];
    // Word count is capped at 127
    assign wordCnt = cmdArg1[7] ? 7'd127 : cmdArg1[6:0];

    // ======================================================================
    // Sample memory fill
    // ======================================================================
    always_ff @(posedge clk) begin
        if (state == Fill) begin
            mem[fillAddr] <= patternWord(fillAddr);
        end
    end

    // ======================================================================
    // Command handling
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= Fill;
            fillAddr  <= '0;
            rdAddr    <= '0;
            hiNext    <= 1'b1;
            led       <= '0;
            sendStart <= 1'b0;
            sendType  <= Nop;
            sendLen   <= '0;
        end else begin
            case (state)
                Fill: begin
                    fillAddr <= fillAddr + 1'b1;
                    if (fillAddr == addrW'(`MEM_WORDS - 1)) begin
                        state <= Idle;
                    end
                end
                Idle: begin
                    if (!inEmpty) begin
                        cmdType <= inFront.msgType;
                        cmdArg0 <= inFront.payload[0];
                        cmdArg1 <= inFront.payload[1];
                        state   <= Decode;
                    end
                end
                Decode: begin
                    state <= Idle;
                    case (cmdType)
                        SetLed: led <= cmdArg0[3:0];
                        ReadMem: begin
                            sendStart <= 1'b1;
                            sendType  <= ReadMem;
                            sendLen   <= {wordCnt, 1'b0};
                            rdAddr    <= cmdArg0[addrW-1:0];
                            hiNext    <= 1'b1;
                            state     <= Start;
                        end
                        default: ;
                    endcase
                end
                // sendBusy rises one cycle after the start pulse
                Start: begin
                    sendStart <= 1'b0;
                    state     <= Busy;
                end
                Busy: begin
                    if (byteReq) begin
                        payloadByte <= hiNext ? rdWord[15:8] : rdWord[7:0];
                        hiNext      <= !hiNext;
                        if (!hiNext) begin
                            rdAddr <= rdAddr + 1'b1;
                        end
                    end
                    if (!sendBusy) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* debugTop.sv */
`default_nettype none

`include "debug_config.svh"

module debugTop (
    input  logic       clk,
    input  logic       rstN,
    input  logic       debugCs,
    input  logic       debugDi,
    output logic       debugDo,
    output logic [3:0] led
);

    import debugPkg::*;

    // Inbound path
    logic       inPush;
    msgT        inMsg;
    msgT        inFront;
    logic       inEmpty;
    logic       inPop;

    // Engine to sender
    logic       sendStart;
    msgTypeT    sendType;
    logic [7:0] sendLen;
    logic       byteReq;
    logic       sendBusy;
    logic [7:0] payloadByte;

    // Outbound path
    logic       outPush;
    logic [7:0] outItem;
    logic [7:0] outFront;
    logic       outEmpty;
    logic       outFull;
    logic       outPop;

    serialRx i_serialRx (
        .clk(clk), .rstN(rstN), .debugCs(debugCs), .debugDi(debugDi),
        .msgPush(inPush), .msg(inMsg)
    );

    msgQueue #(.itemT(msgT), .depth(`QUEUE_DEPTH)) inQueue (
        .clk(clk), .rstN(rstN), .push(inPush), .item(inMsg), .pop(inPop),
        .front(inFront), .empty(inEmpty), .full()
    );

    cmdEngine i_cmdEngine (
        .clk(clk), .rstN(rstN), .inFront(inFront), .inEmpty(inEmpty), .inPop(inPop),
        .sendStart(sendStart), .sendType(sendType), .sendLen(sendLen),
        .byteReq(byteReq), .sendBusy(sendBusy), .payloadByte(payloadByte), .led(led)
    );

    msgSender i_msgSender (
        .clk(clk), .rstN(rstN), .sendStart(sendStart), .sendType(sendType),
        .sendLen(sendLen), .payloadByte(payloadByte), .qFull(outFull),
        .byteReq(byteReq), .sendBusy(sendBusy), .qPush(outPush), .qItem(outItem)
    );

    msgQueue #(.itemT(logic [7:0]), .depth(`QUEUE_DEPTH)) outQueue (
        .clk(clk), .rstN(rstN), .push(outPush), .item(outItem), .pop(outPop),
        .front(outFront), .empty(outEmpty), .full(outFull)
    );

    serialTx i_serialTx (
        .clk(clk), .rstN(rstN), .debugCs(debugCs), .qFront(outFront),
        .qEmpty(outEmpty), .qPop(outPop), .debugDo(debugDo)
    );

endmodule

`default_nettype wire

/* debug_assert.sv */
`default_nettype none

module queueAssert (
    input logic clk,
    input logic rstN,
    input logic push,
    input logic pop,
    input logic empty,
    input logic full
);

    timeunit 1ns;
    timeprecision 1ps;

    // Front is only valid while the queue holds an item
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN) !(pop && empty))
        else $error("msgQueue popped while empty");

    // A push without a pop leaves at least one item behind
    pushLeavesItem: assert property (@(posedge clk) disable iff (!rstN)
                                     push && !pop |=> !empty)
        else $error("msgQueue empty right after a push");

    emptyAfterReset: assert property (@(posedge clk) !rstN |=> empty)
        else $error("msgQueue not empty after reset");

endmodule

bind msgQueue queueAssert i_queueAssert (
    .clk(clk), .rstN(rstN), .push(push), .pop(pop), .empty(empty), .full(full)
);

`default_nettype wire

/* debugTb.sv */
`default_nettype none

`include "debug_config.svh"

module debugTb;

    timeunit 1ns;
    timeprecision 1ps;

    import debugPkg::*;

    localparam int addrW = `MEM_ADDR_WIDTH;
    // All tests together run for about 1500 cycles
    localparam int timeoutCycles = 20000;

    logic       clk;
    logic       rstN;
    logic       debugCs;
    logic       debugDi;
    logic       debugDo;
    logic [3:0] led;

    // Bytes seen on debugDo in the current session, and the last response payload
    logic [7:0] rxBytes[$];
    logic [7:0] respBytes[$];
    logic [7:0] curByte;
    int         bitPos;
    int         cycleCount = 0;

    debugTop i_dut (
        .clk(clk), .rstN(rstN), .debugCs(debugCs), .debugDi(debugDi),
        .debugDo(debugDo), .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("TESTS FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // ======================================================================
    // Link helpers
    // ======================================================================
    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // debugCs is low, so nothing may leave the DUT
    task automatic checkQuietLink(input int cycles, input string what);
        repeat (cycles) begin
            checkEq(32'(debugDo), 0, what);
            @(posedge clk);
            #1;
        end
    endtask

    // One full-duplex bit; the value read back was launched on this edge
    task automatic shiftBit(input logic din);
        debugDi = din;
        @(posedge clk);
        #1;
        curByte = {curByte[6:0], debugDo};
        bitPos++;
        if (bitPos == 8) begin
            rxBytes.push_back(curByte);
            bitPos = 0;
        end
    endtask

    task automatic sendByte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            shiftBit(b[i]);
        end
    endtask

    task automatic getByte(output logic [7:0] b);
        if (rxBytes.size() == 0) begin
            sendByte(8'h00);
        end
        b = rxBytes.pop_front();
    endtask

    task automatic beginSession();
        debugCs = 1'b1;
        bitPos  = 0;
        rxBytes.delete();
    endtask

    task automatic endSession();
        logic [7:0] b;
        while (rxBytes.size() > 0) begin
            b = rxBytes.pop_front();
            checkEq(32'(b), 0, "unexpected byte on debugDo");
        end
        debugCs = 1'b0;
        debugDi = 1'b0;
        bitPos  = 0;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic collectResponse(output logic [7:0] rType, output logic [7:0] rLen);
        logic [7:0] b;
        respBytes.delete();
        // Idle link carries zero bytes until the type arrives
        do begin
            getByte(b);
        end while (b == 8'h00);
        rType = b;
        getByte(rLen);
        for (int i = 0; i < int'(rLen); i++) begin
            getByte(b);
            respBytes.push_back(b);
        end
    endtask

    task automatic waitLed(input logic [3:0] expected, input string what);
        int n;
        n = 0;
        while (led !== expected && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        checkEq(32'(led), 32'(expected), what);
    endtask

    task automatic sendSetLed(input logic [7:0] value);
        sendByte(SetLed);
        sendByte(8'd1);
        sendByte(value);
    endtask

    task automatic sendReadMem(input logic [7:0] startAddr, input logic [7:0] count);
        sendByte(ReadMem);
        sendByte(8'd2);
        sendByte(startAddr);
        sendByte(count);
    endtask

    // Word at addr: addr in the high byte, its inverse in the low byte
    task automatic checkReadMem(input logic [7:0] startAddr, input logic [7:0] count);
        logic [7:0]       rType;
        logic [7:0]       rLen;
        logic [addrW-1:0] wa;
        logic [7:0]       expHi;
        logic [7:0]       expLo;
        collectResponse(rType, rLen);
        checkEq(32'(rType), 32'(ReadMem), "ReadMem response type");
        checkEq(32'(rLen), 32'(count) * 2, "ReadMem response length");
        for (int i = 0; i < int'(count); i++) begin
            wa    = addrW'((int'(startAddr) + i) % `MEM_WORDS);
            expHi = 8'(wa);
            expLo = ~expHi;
            checkEq(32'(respBytes[2*i]), 32'(expHi), "ReadMem high byte");
            checkEq(32'(respBytes[2*i+1]), 32'(expLo), "ReadMem low byte");
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic testReset();
        checkEq(32'(led), 0, "led after reset");
        checkQuietLink(8, "debugDo with debugCs low");
    endtask

    task automatic testSetLed();
        beginSession();
        sendSetLed(8'h5A);
        endSession();
        waitLed(4'hA, "led after SetLed 0x5A");
        beginSession();
        sendSetLed(8'h03);
        endSession();
        waitLed(4'h3, "led after SetLed 0x03");
    endtask

    task automatic testReadMem();
        logic [7:0] a;
        logic [7:0] c;
        a = 8'($urandom_range(`MEM_WORDS - 1, 0));
        c = 8'($urandom_range(8, 1));
        beginSession();
        sendReadMem(a, c);
        endSession();
        // Response waits in the outbound queue while the link is deselected
        checkQuietLink(40, "debugDo with a response pending");
        beginSession();
        checkReadMem(a, c);
        endSession();
    endtask

    // Leading no-ops, then an over-long SetLed that must stay framed
    task automatic testFraming();
        logic [7:0] a;
        logic [7:0] c;
        a = 8'($urandom_range(`MEM_WORDS - 1, 0));
        c = 8'($urandom_range(8, 1));
        beginSession();
        repeat (3) sendByte(8'h00);
        sendByte(SetLed);
        sendByte(8'd9);
        sendByte(8'h37);
        for (int i = 1; i < 9; i++) begin
            sendByte(8'(i));
        end
        sendReadMem(a, c);
        checkReadMem(a, c);
        endSession();
        checkEq(32'(led), 32'h7, "led after long SetLed");
    endtask

    // Second response is long enough to fill the outbound queue
    task automatic testBackToBack();
        logic [7:0] a1;
        logic [7:0] c1;
        logic [7:0] a2;
        a1 = 8'($urandom_range(`MEM_WORDS - 1, 0));
        c1 = 8'($urandom_range(8, 1));
        a2 = 8'($urandom_range(`MEM_WORDS - 1, 0));
        beginSession();
        sendReadMem(a1, c1);
        sendReadMem(a2, 8'd12);
        checkReadMem(a1, c1);
        checkReadMem(a2, 8'd12);
        endSession();
    endtask

    task automatic testDroppedCs();
        beginSession();
        sendSetLed(8'h06);
        endSession();
        waitLed(4'h6, "led before dropped session");
        beginSession();
        sendByte(SetLed);
        sendByte(8'd1);
        repeat (3) shiftBit(1'b1);
        endSession();
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        checkEq(32'(led), 32'h6, "led after partial message");
        beginSession();
        sendSetLed(8'h0C);
        endSession();
        waitLed(4'hC, "led after next full SetLed");
    endtask

    initial begin
        void'($urandom(32'h9d8a276f));
        rstN    = 1'b0;
        debugCs = 1'b0;
        debugDi = 1'b0;
        bitPos  = 0;
        curByte = 8'h00;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        testReset();
        testSetLed();
        testReadMem();
        testFraming();
        testBackToBack();
        testDroppedCs();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
debugPkg.sv
msgQueue.sv
serialRx.sv
serialTx.sv
msgSender.sv
cmdEngine.sv
debugTop.sv
debug_assert.sv
debugTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench; a $fatal gives a nonzero exit status
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps --top-module debugTb \
        -f all.f -o debugSim \
    && ./obj_dir/debugSim \
    || exit 1
